//--- xge_tx_settings.svh
`ifndef XGE_TX_SETTINGS_SVH
`define XGE_TX_SETTINGS_SVH

// Stream word width in bits
`define XGE_DATA_W 64

// Width of the payload byte count
`define XGE_LEN_W 16

// Alignment bytes in front of every packet
`define XGE_PAD_BYTES 6

// Start of frame flag inside the user field
`define XGE_SOF_BIT 3

`endif

//--- xge_tx_pkg.sv
`default_nettype none

`include "xge_tx_settings.svh"

package xge_tx_pkg;

   // One stream word with byte 0 in the low bits
   typedef logic [`XGE_DATA_W-1:0] data_t;

   // Occupancy in [2:0] and start of frame in the top bit
   typedef logic [`XGE_SOF_BIT:0] user_t;

   // Valid bytes in a last word where 0 stands for a full word
   typedef logic [2:0] occ_t;

   typedef logic [`XGE_LEN_W-1:0] len_t;

   // Pad strip sequencing
   typedef enum logic [1:0] {
      store_first,
      forward_full,
      release_last
   } strip_state_t;

endpackage

`default_nettype wire

//--- xge_pad_strip.sv
`timescale 1ns/100ps
`default_nettype none

`include "xge_tx_settings.svh"

module xge_pad_strip (
   input  wire logic                clk,
   input  wire logic                rst_n,
   input  wire logic                clear,
   input  wire xge_tx_pkg::data_t   s_tdata,
   input  wire xge_tx_pkg::user_t   s_tuser,
   input  wire logic                s_tlast,
   input  wire logic                s_tvalid,
   output logic                     s_tready,
   output xge_tx_pkg::data_t        mid_tdata,
   output xge_tx_pkg::user_t        mid_tuser,
   output logic                     mid_tlast,
   output logic                     mid_tvalid,
   input  wire logic                mid_tready
);

   // Bytes of a word that survive the shift into the next output word
   localparam int keep_bytes = 8 - `XGE_PAD_BYTES;
   localparam int keep_w = keep_bytes * 8;
   localparam xge_tx_pkg::occ_t occ_shift = 3'(keep_bytes);

   xge_tx_pkg::strip_state_t state;
   logic [keep_w-1:0]        saved;
   xge_tx_pkg::occ_t         last_occ;
   logic                     last_sof;
   xge_tx_pkg::occ_t         s_occ;
   logic                     s_beat;
   logic                     mid_beat;
   logic                     last_line;

   assign s_occ = s_tuser[2:0];
   assign s_beat = s_tvalid && s_tready;
   assign mid_beat = mid_tvalid && mid_tready;

   // Final input word fits without a trailing word
   assign last_line = s_tlast && (s_occ != 3'd7) && (s_occ != 3'd0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= xge_tx_pkg::store_first;
         last_occ <= '0;
         last_sof <= 1'b0;
      end else if (clear) begin
         state <= xge_tx_pkg::store_first;
         last_occ <= '0;
         last_sof <= 1'b0;
      end else begin
         if (s_beat) begin
            last_occ <= s_occ;
            // Only the word after the padded one opens the frame
            last_sof <= (state == xge_tx_pkg::store_first);
         end
         case (state)
            xge_tx_pkg::store_first: begin
               if (s_beat) begin
                  state <= xge_tx_pkg::forward_full;
               end
            end
            xge_tx_pkg::forward_full: begin
               if (s_beat && s_tlast) begin
                  state <= last_line ? xge_tx_pkg::store_first : xge_tx_pkg::release_last;
               end
            end
            xge_tx_pkg::release_last: begin
               if (mid_beat) begin
                  state <= xge_tx_pkg::store_first;
               end
            end
            default: begin
               state <= xge_tx_pkg::store_first;
            end
         endcase
      end
   end

   // Upper bytes carried into the next output word
   always_ff @(posedge clk) begin
      if (s_beat) begin
         saved <= s_tdata[`XGE_DATA_W-1 -: keep_w];
      end
   end

   always_comb begin
      mid_tuser = '0;
      mid_tuser[`XGE_SOF_BIT] = last_sof;
      mid_tdata = {s_tdata[`XGE_DATA_W-keep_w-1:0], saved};
      case (state)
         xge_tx_pkg::forward_full: begin
            s_tready = mid_tready;
            mid_tvalid = s_tvalid;
            mid_tlast = last_line;
            // Middle words are always full after the shift
            mid_tuser[2:0] = last_line ? s_occ + occ_shift : 3'd0;
         end
         xge_tx_pkg::release_last: begin
            s_tready = 1'b0;
            mid_tvalid = 1'b1;
            mid_tlast = 1'b1;
            mid_tuser[2:0] = last_occ + occ_shift;
            mid_tdata = {{(`XGE_DATA_W-keep_w){1'b0}}, saved};
         end
         default: begin
            // Padded first word is swallowed
            s_tready = 1'b1;
            mid_tvalid = 1'b0;
            mid_tlast = 1'b0;
            mid_tuser[2:0] = 3'd0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- xge_frame_meter.sv
`timescale 1ns/100ps
`default_nettype none

`include "xge_tx_settings.svh"

module xge_frame_meter (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               clear,
   input  wire xge_tx_pkg::user_t  s_tuser,
   input  wire logic               s_tlast,
   input  wire logic               s_tvalid,
   input  wire logic               s_tready,
   output xge_tx_pkg::len_t        frame_len_q
);

   localparam xge_tx_pkg::len_t word_bytes = xge_tx_pkg::len_t'(`XGE_DATA_W / 8);
   localparam xge_tx_pkg::len_t pad_bytes = xge_tx_pkg::len_t'(`XGE_PAD_BYTES);

   xge_tx_pkg::len_t count;
   xge_tx_pkg::len_t last_bytes;
   logic             beat;

   // Same handshake as the strip block sees
   assign beat = s_tvalid && s_tready;

   // Occupancy of zero means a full last word
   always_comb begin
      if (s_tuser[2:0] == 3'd0) begin
         last_bytes = word_bytes;
      end else begin
         last_bytes = xge_tx_pkg::len_t'(s_tuser[2:0]);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
         frame_len_q <= '0;
      end else if (clear) begin
         count <= '0;
         frame_len_q <= '0;
      end else if (beat) begin
         if (s_tlast) begin
            // Payload excludes the alignment pad
            frame_len_q <= count + last_bytes - pad_bytes;
            count <= '0;
         end else begin
            count <= count + word_bytes;
         end
      end
   end

endmodule

`default_nettype wire

//--- xge_tx_out_stage.sv
`timescale 1ns/100ps
`default_nettype none

module xge_tx_out_stage (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               clear,
   input  wire xge_tx_pkg::data_t  mid_tdata,
   input  wire xge_tx_pkg::user_t  mid_tuser,
   input  wire logic               mid_tlast,
   input  wire logic               mid_tvalid,
   output logic                    mid_tready,
   input  wire xge_tx_pkg::len_t   frame_len_q,
   output xge_tx_pkg::data_t       m_tdata,
   output xge_tx_pkg::user_t       m_tuser,
   output logic                    m_tlast,
   output logic                    m_tvalid,
   input  wire logic               m_tready,
   output xge_tx_pkg::len_t        frame_len,
   output logic                    frame_len_valid
);

   logic load;
   logic leave;

   // Take a new word when empty or when the held one leaves now
   assign mid_tready = !m_tvalid || m_tready;
   assign load = mid_tvalid && mid_tready;
   assign leave = m_tvalid && m_tready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         m_tvalid <= 1'b0;
      end else if (clear) begin
         m_tvalid <= 1'b0;
      end else if (load) begin
         m_tvalid <= 1'b1;
      end else if (leave) begin
         m_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         m_tdata <= mid_tdata;
         m_tuser <= mid_tuser;
         m_tlast <= mid_tlast;
      end
   end

   // The meter cannot move on before this last word has left
   assign frame_len_valid = leave && m_tlast;
   assign frame_len = frame_len_valid ? frame_len_q : '0;

endmodule

`default_nettype wire

//--- xge_tx_align.sv
`timescale 1ns/100ps
`default_nettype none

module xge_tx_align (
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               clear,
   input  wire xge_tx_pkg::data_t  s_tdata,
   input  wire xge_tx_pkg::user_t  s_tuser,
   input  wire logic               s_tlast,
   input  wire logic               s_tvalid,
   output wire logic               s_tready,
   output wire xge_tx_pkg::data_t  m_tdata,
   output wire xge_tx_pkg::user_t  m_tuser,
   output wire logic               m_tlast,
   output wire logic               m_tvalid,
   input  wire logic               m_tready,
   output wire xge_tx_pkg::len_t   frame_len,
   output wire logic               frame_len_valid
);

   // Realigned stream between strip block and output slice
   xge_tx_pkg::data_t mid_tdata;
   xge_tx_pkg::user_t mid_tuser;
   logic              mid_tlast;
   logic              mid_tvalid;
   logic              mid_tready;
   xge_tx_pkg::len_t  frame_len_q;

   xge_pad_strip u_pad_strip (
      .clk        (clk),
      .rst_n      (rst_n),
      .clear      (clear),
      .s_tdata    (s_tdata),
      .s_tuser    (s_tuser),
      .s_tlast    (s_tlast),
      .s_tvalid   (s_tvalid),
      .s_tready   (s_tready),
      .mid_tdata  (mid_tdata),
      .mid_tuser  (mid_tuser),
      .mid_tlast  (mid_tlast),
      .mid_tvalid (mid_tvalid),
      .mid_tready (mid_tready)
   );

   // Watches the same accepted input beats as the strip block
   xge_frame_meter u_frame_meter (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (clear),
      .s_tuser     (s_tuser),
      .s_tlast     (s_tlast),
      .s_tvalid    (s_tvalid),
      .s_tready    (s_tready),
      .frame_len_q (frame_len_q)
   );

   xge_tx_out_stage u_out_stage (
      .clk             (clk),
      .rst_n           (rst_n),
      .clear           (clear),
      .mid_tdata       (mid_tdata),
      .mid_tuser       (mid_tuser),
      .mid_tlast       (mid_tlast),
      .mid_tvalid      (mid_tvalid),
      .mid_tready      (mid_tready),
      .frame_len_q     (frame_len_q),
      .m_tdata         (m_tdata),
      .m_tuser         (m_tuser),
      .m_tlast         (m_tlast),
      .m_tvalid        (m_tvalid),
      .m_tready        (m_tready),
      .frame_len       (frame_len),
      .frame_len_valid (frame_len_valid)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   // Reset held over the first two rising edges
   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

   // 8 ns period
   always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- xge_tx_align_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module xge_tx_align_assertions (
   input wire logic               clk,
   input wire logic               rst_n,
   input wire logic               clear,
   input wire xge_tx_pkg::data_t  m_tdata,
   input wire xge_tx_pkg::user_t  m_tuser,
   input wire logic               m_tlast,
   input wire logic               m_tvalid,
   input wire logic               m_tready,
   input wire xge_tx_pkg::len_t   frame_len,
   input wire logic               frame_len_valid
);

   int fail_count = 0;
   xge_tx_pkg::len_t sent_bytes;
   xge_tx_pkg::len_t word_bytes;

   // Bytes in the word on the port where a last word counts its occupancy
   assign word_bytes = (m_tlast && m_tuser[2:0] != 3'd0) ? xge_tx_pkg::len_t'(m_tuser[2:0])
      : xge_tx_pkg::len_t'(8);

   // Bytes of the current frame that already left
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sent_bytes <= '0;
      end else if (clear) begin
         sent_bytes <= '0;
      end else if (m_tvalid && m_tready) begin
         sent_bytes <= m_tlast ? '0 : sent_bytes + word_bytes;
      end
   end

   // A stalled output word keeps its valid and its contents
   stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
      m_tvalid && !m_tready && !clear |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
         && $stable(m_tlast))
   else begin
      fail_count++;
      $error("output word changed while stalled");
   end

   // Length strobe only with the last word leaving and matching the bytes sent
   len_with_last: assert property (@(posedge clk) disable iff (!rst_n)
      frame_len_valid |-> m_tvalid && m_tready && m_tlast
         && frame_len == sent_bytes + word_bytes)
   else begin
      fail_count++;
      $error("frame_len_valid without a matching m_tlast transfer");
   end

   reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !m_tvalid && !frame_len_valid)
   else begin
      fail_count++;
      $error("output not idle after reset");
   end

endmodule

`default_nettype wire

//--- xge_tx_align_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "xge_tx_settings.svh"

module xge_tx_align_tb;

   localparam int num_rows = 12;

   // Hex digits per row give beats, last occupancy, back-pressure and clear before frame
   logic [15:0] rows [num_rows] = '{16'h2100, 16'h2600, 16'h2700, 16'h2001, 16'h3300,
      16'h4010, 16'h5710, 16'h9511, 16'h6200, 16'h7610, 16'h8111, 16'h9010};

   logic clk, rst_n, clear, s_tlast, s_tvalid, s_tready;
   logic m_tlast, m_tvalid, m_tready, frame_len_valid, bp_mode;
   xge_tx_pkg::data_t s_tdata, m_tdata;
   xge_tx_pkg::user_t s_tuser, m_tuser;
   xge_tx_pkg::len_t  frame_len, got_len;
   xge_tx_pkg::occ_t  got_occ;
   logic [7:0]        in_bytes[$], out_bytes[$];
   integer            seed = 32'ha0ad;
   int data_errs = 0, ctrl_errs = 0, miss_errs = 0;
   int word_idx = 0, frames_done = 0, len_pulses = 0, got_words = 0;

   tb_clock_gen u_clock_gen (.clk(clk), .rst_n(rst_n));

   xge_tx_align dut (.*);

   bind xge_tx_align xge_tx_align_assertions u_assertions (.*);

   always @(negedge clk) begin
      m_tready = bp_mode ? (($random(seed) & 3) != 0) : 1'b1;
   end

   // Collector that reassembles the output bytes of the current frame
   always @(posedge clk) begin
      int n;
      if (frame_len_valid) begin
         len_pulses++;
         got_len = frame_len;
      end
      if (m_tvalid && m_tready) begin
         n = (m_tlast && m_tuser[2:0] != 3'd0) ? m_tuser[2:0] : 8;
         for (int i = 0; i < n; i++)
            out_bytes.push_back(m_tdata[8*i +: 8]);
         if (m_tuser[`XGE_SOF_BIT] != (word_idx == 0)) begin
            $display("[ERROR] m_tuser sof: expected %h, got %h", word_idx == 0,
               m_tuser[`XGE_SOF_BIT]);
            ctrl_errs++;
         end
         word_idx++;
         if (m_tlast) begin
            got_words = word_idx;
            got_occ = m_tuser[2:0];
            word_idx = 0;
            frames_done++;
         end
      end
   end

   task automatic send_frame(input int beats, input xge_tx_pkg::occ_t occ);
      int last_bytes;
      last_bytes = (occ == 3'd0) ? 8 : occ;
      for (int b = 0; b < beats; b++) begin
         for (int i = 0; i < 8; i++) begin
            s_tdata[8*i +: 8] = $random(seed);
            if (b < beats - 1 || i < last_bytes)
               in_bytes.push_back(s_tdata[8*i +: 8]);
         end
         s_tlast = (b == beats - 1);
         s_tuser = s_tlast ? occ : '0;
         s_tvalid = 1'b1;
         @(posedge clk);
         while (!s_tready)
            @(posedge clk);
         @(negedge clk);
      end
      s_tvalid = 1'b0;
      s_tlast = 1'b0;
   endtask

   task automatic check_frame(input int row, input int beats, input xge_tx_pkg::occ_t occ);
      int payload;
      payload = 8 * (beats - 1) + ((occ == 3'd0) ? 8 : occ) - `XGE_PAD_BYTES;
      if (got_words != (payload + 7) / 8) begin
         $display("[ERROR] row %0d word count: expected %h, got %h", row, (payload + 7) / 8,
            got_words);
         ctrl_errs++;
      end
      if (got_occ != xge_tx_pkg::occ_t'(payload % 8)) begin
         $display("[ERROR] row %0d m_tuser occupancy: expected %h, got %h", row,
            xge_tx_pkg::occ_t'(payload % 8), got_occ);
         ctrl_errs++;
      end
      if (len_pulses != 1 || got_len != xge_tx_pkg::len_t'(payload)) begin
         $display("[ERROR] row %0d frame_len: expected %h, got %h (%0d strobes)", row,
            xge_tx_pkg::len_t'(payload), got_len, len_pulses);
         ctrl_errs++;
      end
      if (out_bytes.size() != payload) begin
         $display("[ERROR] row %0d byte count: expected %h, got %h", row, payload,
            out_bytes.size());
         data_errs++;
      end
      for (int i = 0; i < out_bytes.size() && i + `XGE_PAD_BYTES < in_bytes.size(); i++) begin
         if (out_bytes[i] != in_bytes[i + `XGE_PAD_BYTES]) begin
            $display("[ERROR] row %0d m_tdata byte %0d: expected %h, got %h", row, i,
               in_bytes[i + `XGE_PAD_BYTES], out_bytes[i]);
            data_errs++;
            break;
         end
      end
   endtask

   task automatic report_counts();
      $display("Errors: %0d data, %0d control, %0d missing, %0d assertion", data_errs,
         ctrl_errs, miss_errs, dut.u_assertions.fail_count);
   endtask

   initial begin
      int beats;
      int wait_cycles;
      xge_tx_pkg::occ_t occ;
      clear = 1'b0;
      s_tdata = '0;
      s_tuser = '0;
      s_tlast = 1'b0;
      s_tvalid = 1'b0;
      m_tready = 1'b1;
      bp_mode = 1'b0;
      wait (rst_n === 1'b1);
      @(negedge clk);
      for (int r = 0; r < num_rows; r++) begin
         beats = rows[r][15:12];
         occ = rows[r][10:8];
         bp_mode = rows[r][4];
         if (rows[r][0]) begin
            clear = 1'b1;
            @(negedge clk);
            clear = 1'b0;
         end
         in_bytes.delete();
         out_bytes.delete();
         len_pulses = 0;
         frames_done = 0;
         send_frame(beats, occ);
         wait_cycles = 0;
         while (frames_done == 0 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
         end
         if (frames_done == 0) begin
            $display("Frame of row %0d never came out of the DUT", r);
            miss_errs++;
         end else begin
            check_frame(r, beats, occ);
         end
      end
      report_counts();
      if (data_errs + ctrl_errs + miss_errs + dut.u_assertions.fail_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   // 40 cycles per table row
   initial begin
      repeat (num_rows * 40 + 4) @(posedge clk);
      $display("Watchdog expired, the run did not finish in time");
      report_counts();
      $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
xge_tx_pkg.sv
xge_pad_strip.sv
xge_frame_meter.sv
xge_tx_out_stage.sv
xge_tx_align.sv
tb_clock_gen.sv
xge_tx_align_assertions.sv
xge_tx_align_tb.sv
